// File: hw/mem_test_pkg.sv
// ------------------------------------------------------------
// memory test constants and pattern rule
// ------------------------------------------------------------
package mem_test_pkg;

	// word and address widths of the controller user port
	localparam int data_w = 32;
	localparam int addr_w = 10;

	// words exercised per pass, from address 0 upward
	// must fit inside the 1024-word address space
	localparam int test_depth = 16;

	// last address of a burst, in address width
	localparam logic [addr_w-1:0] test_last = addr_w'(test_depth - 1);

	// pass number width, wraps after 256 passes
	localparam int pass_w = 8;

	// ------------------------------------------------------------
	// pattern constants
	// ------------------------------------------------------------

	// mixed into every word so that address 0 is not all zeros
	localparam logic [data_w-1:0] pattern_seed = 32'ha5c3_0f69;

	// odd passes flip every bit
	// each cell then sees both polarities over two passes
	localparam logic [data_w-1:0] invert_mask = {data_w{1'b1}};

	// phases of the traffic generator
	// idle   waiting for the test reset to release
	// write  one write command per cycle
	// read   one read command per cycle
	// drain  waiting for the last returns of the pass
	typedef enum logic [1:0] {
		ph_idle  = 2'd0,
		ph_write = 2'd1,
		ph_read  = 2'd2,
		ph_drain = 2'd3
	} gen_phase_t;

	// ------------------------------------------------------------
	// pattern rule
	// ------------------------------------------------------------

	// expected word for an address on a pass of the given parity
	// generator, checker and model all use this one rule
	function automatic logic [data_w-1:0] pattern_word(
		input logic [addr_w-1:0] addr,
		input logic              odd
	);
		logic [data_w-1:0] word;
		// zero-extend the address, then the seed
		word = data_w'(addr) ^ pattern_seed;
		// inversion on odd passes only
		if (odd) begin
			word = word ^ invert_mask;
		end
		return word;
	endfunction

endpackage

// File: hw/board_status_pkg.sv
// ------------------------------------------------------------
// board status outputs
// ------------------------------------------------------------
package board_status_pkg;

	// five LEDs on the board header
	localparam int led_w = 5;

	// bits 0 and 1 carry no status, tied low
	localparam int led_calib = 2;

	// active low error indicator
	// lit while no miscompare has been seen
	localparam int led_error_n = 3;

	// toggles once per completed pass
	localparam int led_run = 4;

	// miscompare counter width
	localparam int err_cnt_w = 16;

	// saturation value of the miscompare counter
	localparam logic [err_cnt_w-1:0] err_cnt_max = {err_cnt_w{1'b1}};

endpackage

// File: hw/calib_reset_gate.sv
`timescale 1ns/1ps

module calib_reset_gate (
	input  logic w_clk_out3,
	input  logic w_reset_clk3,
	input  logic calib_done,
	output logic calib_sync,
	output logic test_rst
);

	// first synchronizer stage, may go metastable
	logic calib_meta;

	// ------------------------------------------------------------
	// calibration-done synchronizer
	// ------------------------------------------------------------

	// calib_done comes from the controller's calibration logic
	// two flops before anything reads it
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			calib_meta <= 1'b0;
			calib_sync <= 1'b0;
		end else begin
			calib_meta <= calib_done;
			calib_sync <= calib_meta;
		end
	end

	// ------------------------------------------------------------
	// test reset
	// ------------------------------------------------------------

	// held while the synchronized flag is low
	// releases one clock after calib_sync rises
	// any calibration loss puts the test back in reset
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			test_rst <= 1'b1;
		end else begin
			test_rst <= ~calib_sync;
		end
	end

endmodule

// File: hw/traffic_gen.sv
`timescale 1ns/1ps

module traffic_gen (
	input  logic                            w_clk_out3,
	input  logic                            w_reset_clk3,
	input  logic                            test_rst,
	input  logic                            pass_done,
	output logic                            cmd_wr,
	output logic                            cmd_rd,
	output logic [mem_test_pkg::addr_w-1:0] cmd_addr,
	output logic [mem_test_pkg::data_w-1:0] wr_data,
	output logic                            pass_odd,
	output logic [mem_test_pkg::pass_w-1:0] pass_count
);

	import mem_test_pkg::*;

	// current phase of the pass
	gen_phase_t phase;

	// address of the command issued this cycle
	logic [addr_w-1:0] addr;

	// end of a burst
	logic burst_last;

	assign burst_last = (addr == test_last);

	// ------------------------------------------------------------
	// phase machine
	// ------------------------------------------------------------

	// idle -> write -> read -> drain -> write ...
	// test_rst drops any pass in progress back to idle
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			phase <= ph_idle;
			addr  <= '0;
		end else if (test_rst) begin
			// abort, next start is from address 0
			phase <= ph_idle;
			addr  <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					// first write one clock after release
					phase <= ph_write;
					addr  <= '0;
				end
				ph_write: begin
					if (burst_last) begin
						phase <= ph_read;
						addr  <= '0;
					end else begin
						addr <= addr + 1'b1;
					end
				end
				ph_read: begin
					if (burst_last) begin
						phase <= ph_drain;
						addr  <= '0;
					end else begin
						addr <= addr + 1'b1;
					end
				end
				ph_drain: begin
					// reads still in flight
					// checker says when the last one is back
					if (pass_done) begin
						phase <= ph_write;
						addr  <= '0;
					end
				end
				default: begin
					phase <= ph_idle;
					addr  <= '0;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// pass counter
	// ------------------------------------------------------------

	// only the board reset clears it
	// keeps counting across calibration drops
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			pass_count <= '0;
		end else if (pass_done && phase == ph_drain) begin
			pass_count <= pass_count + 1'b1;
		end
	end

	// pattern variant follows the pass number
	assign pass_odd = pass_count[0];

	// ------------------------------------------------------------
	// command port
	// ------------------------------------------------------------

	// one strobe per cycle in the burst phases
	// never both at once since the phases are exclusive
	assign cmd_wr = (phase == ph_write);
	assign cmd_rd = (phase == ph_read);

	assign cmd_addr = addr;

	// data only matters in write cycles
	assign wr_data = pattern_word(addr, pass_odd);

endmodule

// File: hw/read_checker.sv
`timescale 1ns/1ps

module read_checker (
	input  logic                            w_clk_out3,
	input  logic                            w_reset_clk3,
	input  logic                            test_rst,
	input  logic                            rd_valid,
	input  logic [mem_test_pkg::data_w-1:0] rd_data,
	input  logic                            pass_odd,
	output logic                            pass_done,
	output logic                            err_strobe
);

	import mem_test_pkg::*;

	// address of the next read return
	// returns come back in issue order
	logic [addr_w-1:0] ret_addr;

	// word this return should carry
	logic [data_w-1:0] exp_word;

	// miscompare on the current return
	logic mismatch;

	// last return of the pass
	logic ret_last;

	// ------------------------------------------------------------
	// compare
	// ------------------------------------------------------------

	// same rule as the write side
	// pass parity does not change until pass_done
	assign exp_word = pattern_word(ret_addr, pass_odd);

	assign mismatch = rd_valid && (rd_data != exp_word);

	assign ret_last = rd_valid && (ret_addr == test_last);

	// ------------------------------------------------------------
	// return counter
	// ------------------------------------------------------------

	// wraps to 0 after the last word of the pass
	// test_rst drops a partial pass
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			ret_addr <= '0;
		end else if (test_rst) begin
			ret_addr <= '0;
		end else if (rd_valid) begin
			if (ret_last) begin
				ret_addr <= '0;
			end else begin
				ret_addr <= ret_addr + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------

	// pass_done one clock after the last return
	// err_strobe one clock after a bad word
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			pass_done  <= 1'b0;
			err_strobe <= 1'b0;
		end else if (test_rst) begin
			pass_done  <= 1'b0;
			err_strobe <= 1'b0;
		end else begin
			pass_done  <= ret_last;
			err_strobe <= mismatch;
		end
	end

endmodule

// File: hw/status_leds.sv
`timescale 1ns/1ps

module status_leds (
	input  logic                                  w_clk_out3,
	input  logic                                  w_reset_clk3,
	input  logic                                  calib_sync,
	input  logic                                  pass_done,
	input  logic                                  err_strobe,
	output logic [board_status_pkg::led_w-1:0]     fpga_led,
	output logic [board_status_pkg::err_cnt_w-1:0] err_count
);

	import board_status_pkg::*;

	// flips on every completed pass
	logic run_flag;

	// output stage of the run indicator
	logic run_led;

	// set by the first miscompare, cleared only by board reset
	logic err_seen;

	// ------------------------------------------------------------
	// run indicator
	// ------------------------------------------------------------

	// two registers from pass_done to the pin
	// LED changes 2 clocks after the strobe
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			run_flag <= 1'b0;
			run_led  <= 1'b0;
		end else begin
			if (pass_done) begin
				run_flag <= ~run_flag;
			end
			run_led <= run_flag;
		end
	end

	// ------------------------------------------------------------
	// error latch and counter
	// ------------------------------------------------------------

	// counter sticks at its maximum
	always_ff @(posedge w_clk_out3 or posedge w_reset_clk3) begin
		if (w_reset_clk3) begin
			err_seen  <= 1'b0;
			err_count <= '0;
		end else if (err_strobe) begin
			err_seen <= 1'b1;
			if (err_count != err_cnt_max) begin
				err_count <= err_count + 1'b1;
			end
		end
	end

	// LED word, unused bits stay dark
	always_comb begin
		fpga_led              = '0;
		fpga_led[led_calib]   = calib_sync;
		fpga_led[led_error_n] = ~err_seen;
		fpga_led[led_run]     = run_led;
	end

endmodule

// File: hw/ddr_verify_top.sv
`timescale 1ns/1ps

module ddr_verify_top (
	input  logic                                  w_clk_out3,
	input  logic                                  w_reset_clk3,
	input  logic                                  calib_done,
	output logic                                  cmd_wr,
	output logic                                  cmd_rd,
	output logic [mem_test_pkg::addr_w-1:0]       cmd_addr,
	output logic [mem_test_pkg::data_w-1:0]       wr_data,
	input  logic                                  rd_valid,
	input  logic [mem_test_pkg::data_w-1:0]       rd_data,
	output logic [board_status_pkg::led_w-1:0]     fpga_led,
	output logic [board_status_pkg::err_cnt_w-1:0] err_count,
	output logic [mem_test_pkg::pass_w-1:0]       pass_count
);

	// reset gate outputs
	logic calib_sync;
	logic test_rst;

	// generator to checker
	logic pass_odd;

	// checker strobes
	logic pass_done;
	logic err_strobe;

	// ------------------------------------------------------------
	// input side
	// ------------------------------------------------------------

	calib_reset_gate u_calib_reset_gate (
		.w_clk_out3   (w_clk_out3),
		.w_reset_clk3 (w_reset_clk3),
		.calib_done   (calib_done),
		.calib_sync   (calib_sync),
		.test_rst     (test_rst)
	);

	// ------------------------------------------------------------
	// traffic and compare
	// ------------------------------------------------------------

	traffic_gen u_traffic_gen (
		.w_clk_out3   (w_clk_out3),
		.w_reset_clk3 (w_reset_clk3),
		.test_rst     (test_rst),
		.pass_done    (pass_done),
		.cmd_wr       (cmd_wr),
		.cmd_rd       (cmd_rd),
		.cmd_addr     (cmd_addr),
		.wr_data      (wr_data),
		.pass_odd     (pass_odd),
		.pass_count   (pass_count)
	);

	// sees every return in the cycle it arrives
	read_checker u_read_checker (
		.w_clk_out3   (w_clk_out3),
		.w_reset_clk3 (w_reset_clk3),
		.test_rst     (test_rst),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.pass_odd     (pass_odd),
		.pass_done    (pass_done),
		.err_strobe   (err_strobe)
	);

	// ------------------------------------------------------------
	// output side
	// ------------------------------------------------------------

	status_leds u_status_leds (
		.w_clk_out3   (w_clk_out3),
		.w_reset_clk3 (w_reset_clk3),
		.calib_sync   (calib_sync),
		.pass_done    (pass_done),
		.err_strobe   (err_strobe),
		.fpga_led     (fpga_led),
		.err_count    (err_count)
	);

endmodule

// File: bench/ddr_verify_tb.sv
`timescale 1ns/1ps

module ddr_verify_tb;

	import mem_test_pkg::*;
	import board_status_pkg::*;

	localparam int rows = 4;
	localparam logic [led_w-1:0] calib_mask = led_w'(1 << led_calib);
	localparam logic [led_w-1:0] run_mask = led_w'(1 << led_run);

	logic                 w_clk_out3;
	logic                 w_reset_clk3;
	logic                 calib_done;
	logic                 cmd_wr;
	logic                 cmd_rd;
	logic [addr_w-1:0]    cmd_addr;
	logic [data_w-1:0]    wr_data;
	logic                 rd_valid;
	logic [data_w-1:0]    rd_data;
	logic [led_w-1:0]     fpga_led;
	logic [err_cnt_w-1:0] err_count;
	logic [pass_w-1:0]    pass_count;

	// ------------------------------------------------------------
	// scenario table with one row per scenario
	// ------------------------------------------------------------
	// calib delay, passes, corrupt pass in row (-1 none), corrupt addr,
	// abort after n writes (0 none), expected totals and LED word
	int                row_delay [rows] = '{6, 3, 5, 2};
	int                row_passes [rows] = '{2, 3, 2, 1};
	int                row_cpass [rows] = '{-1, 1, -1, -1};
	logic [addr_w-1:0] row_caddr [rows] = '{10'd0, 10'd5, 10'd0, 10'd0};
	int                row_abort [rows] = '{0, 0, 4, 0};
	int                row_total [rows] = '{2, 5, 7, 8};
	int                row_err [rows] = '{0, 1, 1, 1};
	logic [led_w-1:0]  row_led [rows] = '{5'h0c, 5'h14, 5'h14, 5'h04};

	// controller model state
	logic [data_w-1:0] mem [0:(1 << addr_w) - 1];
	int                ret_cyc_q [$];
	logic [data_w-1:0] ret_data_q [$];
	bit                ret_bad_q [$];
	int                last_ret;
	int                ret_in_pass;

	// tracking and run control
	int                seed;
	int                cycle;
	int                cycle_limit;
	int                exp_pass;
	int                exp_err;
	int                corrupt_abs;
	logic [addr_w-1:0] corrupt_addr;
	int                wr_in_row;
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;
	logic              prev_wr;
	logic              prev_rd;

	ddr_verify_top u_dut (
		.w_clk_out3   (w_clk_out3),
		.w_reset_clk3 (w_reset_clk3),
		.calib_done   (calib_done),
		.cmd_wr       (cmd_wr),
		.cmd_rd       (cmd_rd),
		.cmd_addr     (cmd_addr),
		.wr_data      (wr_data),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.fpga_led     (fpga_led),
		.err_count    (err_count),
		.pass_count   (pass_count)
	);

	// 8 ns board clock
	initial begin
		w_clk_out3 = 1'b0;
		forever #4 w_clk_out3 = ~w_clk_out3;
	end

	// ------------------------------------------------------------
	// expected pattern and checks
	// ------------------------------------------------------------
	// zero-extended address xor seed and inverted on odd passes
	function automatic logic [data_w-1:0] expect_word(input logic [addr_w-1:0] a,
		input int pass_no);
		logic [data_w-1:0] w;
		w = {{(data_w - addr_w){1'b0}}, a} ^ pattern_seed;
		if (pass_no % 2 == 1) begin
			w = w ^ invert_mask;
		end
		return w;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at cycle %0d", cycle);
	endtask

	task automatic check_data(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input logic [addr_w-1:0] got,
		input logic [addr_w-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input logic [err_cnt_w-1:0] got,
		input logic [err_cnt_w-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_leds(input string name, input logic [led_w-1:0] got,
		input logic [led_w-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_no_cmd();
		if (cmd_wr || cmd_rd) begin
			stop_on_error("command strobe seen while the test should be held in reset");
		end
	endtask

	// ------------------------------------------------------------
	// controller model with one call per clock
	// ------------------------------------------------------------
	task automatic step_cycle();
		logic [31:0]       rnd;
		logic [data_w-1:0] stored;
		int                ret;
		@(posedge w_clk_out3);
		#1;
		cycle++;
		if (cycle > cycle_limit) begin
			stop_on_error($sformatf("timeout, run went past %0d cycles", cycle_limit));
		end
		// in-order return due this cycle
		rd_valid = 1'b0;
		rd_data  = '0;
		if (ret_cyc_q.size() > 0 && ret_cyc_q[0] == cycle) begin
			rd_valid = 1'b1;
			rd_data  = ret_data_q[0];
			if (ret_bad_q[0]) begin
				exp_err++;
			end
			void'(ret_cyc_q.pop_front());
			void'(ret_data_q.pop_front());
			void'(ret_bad_q.pop_front());
			ret_in_pass++;
			if (ret_in_pass == test_depth) begin
				ret_in_pass = 0;
				exp_pass++;
			end
		end
		if (cmd_wr && cmd_rd) begin
			stop_on_error("write and read strobes high in the same cycle");
		end
		if (cmd_wr) begin
			// every burst starts over at 0
			if (!prev_wr) begin
				wr_addr = '0;
			end
			check_addr("cmd_addr write", cmd_addr, wr_addr);
			check_data("wr_data", wr_data, expect_word(cmd_addr, exp_pass));
			// run LED settled by the second write of a pass
			if (cmd_addr == addr_w'(1)) begin
				check_leds("fpga_led run", fpga_led & run_mask,
					(exp_pass % 2 == 1) ? run_mask : '0);
			end
			stored = wr_data;
			if (exp_pass == corrupt_abs && cmd_addr == corrupt_addr) begin
				stored = stored ^ 32'h0000_0100;
			end
			mem[cmd_addr] = stored;
			wr_addr = wr_addr + addr_w'(1);
			wr_in_row++;
		end
		if (cmd_rd) begin
			if (!prev_rd) begin
				rd_addr = '0;
			end
			check_addr("cmd_addr read", cmd_addr, rd_addr);
			rd_addr = rd_addr + addr_w'(1);
			// latency of 1 to 8 cycles and never before the previous return
			rnd = $random(seed);
			ret = cycle + 1 + int'(rnd[2:0]);
			if (ret <= last_ret) begin
				ret = last_ret + 1;
			end
			last_ret = ret;
			ret_cyc_q.push_back(ret);
			ret_data_q.push_back(mem[cmd_addr]);
			ret_bad_q.push_back(mem[cmd_addr] != expect_word(cmd_addr, exp_pass));
		end
		prev_wr = cmd_wr;
		prev_rd = cmd_rd;
	endtask

	// ------------------------------------------------------------
	// calibration drop and release
	// ------------------------------------------------------------
	task automatic restart_calib(input int delay);
		calib_done = 1'b0;
		// synchronizer and reset register still draining
		repeat (4) step_cycle();
		for (int k = 0; k < delay; k++) begin
			step_cycle();
			check_no_cmd();
		end
		// counters hold across the drop
		check_count("pass_count", err_cnt_w'(pass_count), err_cnt_w'(exp_pass));
		check_count("err_count", err_count, err_cnt_w'(exp_err));
		calib_done = 1'b1;
		for (int k = 1; k <= 3; k++) begin
			step_cycle();
			check_no_cmd();
			check_leds("fpga_led calib", fpga_led & calib_mask, (k >= 2) ? calib_mask : '0);
		end
		step_cycle();
		if (!cmd_wr) begin
			stop_on_error("no write command one clock after the test reset released");
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		w_reset_clk3 = 1'b1;
		calib_done   = 1'b0;
		rd_valid     = 1'b0;
		rd_data      = '0;
		seed         = 32'hd167_5361;
		cycle        = 0;
		exp_pass     = 0;
		exp_err      = 0;
		last_ret     = 0;
		ret_in_pass  = 0;
		corrupt_abs  = -1;
		corrupt_addr = '0;
		wr_in_row    = 0;
		wr_addr      = '0;
		rd_addr      = '0;
		prev_wr      = 1'b0;
		prev_rd      = 1'b0;
		cycle_limit  = 200;
		for (int i = 0; i < rows; i++) begin
			cycle_limit += row_passes[i] * (2 * test_depth + 8 + 4);
		end
		repeat (2) @(posedge w_clk_out3);
		#1;
		w_reset_clk3 = 1'b0;
		// only error_n lit out of reset
		check_leds("fpga_led", fpga_led, 5'h08);
		check_count("err_count", err_count, '0);
		check_count("pass_count", err_cnt_w'(pass_count), '0);
		check_no_cmd();
		for (int i = 0; i < rows; i++) begin
			corrupt_abs  = (row_cpass[i] >= 0) ? exp_pass + row_cpass[i] : -1;
			corrupt_addr = row_caddr[i];
			restart_calib(row_delay[i]);
			// first write of the restarted burst already seen
			wr_in_row    = 1;
			while (exp_pass < row_total[i]) begin
				step_cycle();
				// mid-pass drop inside the write burst
				if (row_abort[i] != 0 && wr_in_row == row_abort[i]) begin
					restart_calib(row_delay[i]);
				end
			end
			// let pass_count and the run LED catch up
			repeat (3) step_cycle();
			check_count("pass_count", err_cnt_w'(pass_count), err_cnt_w'(row_total[i]));
			check_count("err_count", err_count, err_cnt_w'(row_err[i]));
			check_leds("fpga_led", fpga_led, row_led[i]);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: files.f
hw/mem_test_pkg.sv
hw/board_status_pkg.sv
hw/calib_reset_gate.sv
hw/traffic_gen.sv
hw/read_checker.sv
hw/status_leds.sv
hw/ddr_verify_top.sv
bench/ddr_verify_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the memory soak testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module ddr_verify_tb \
	-f files.f \
	-o ddr_verify_sim

# the run passes only if the pass line shows up in the output
./obj_dir/ddr_verify_sim 2>&1 | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

echo "run_sim.sh: simulation passed"
